/* Makefile */
# Verilator flow for the switch ingress project

VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_top
RTL_TOP   ?= switch_ingress_top
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/100ps
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(SIM_LOG)
	grep -qx "$(PASS_MSG)" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* build.f */
common/switch_pkg.sv
common/frontend_if.sv
port_wr_frontend/port_wr_frontend.sv
source/xfer_arbiter.sv
source/switch_ingress_top.sv
tb/ingress_checker.sv
tb/tb_top.sv

/* common/frontend_if.sv */
interface frontend_if;
    import switch_pkg::*;

    logic                match_enable;   // level, packet waits for grant
    logic                match_suc;      // single cycle grant pulse
    logic                ready_to_xfer;  // comb, high in grant cycle
    logic                xfer_data_vld;
    pkt_word_t           xfer_data;
    logic                end_of_packet;  // with last word
    logic [dport_w-1:0]  new_dest_port;  // decoded header fields
    logic [prio_w-1:0]   new_prior;
    logic [len_w-1:0]    new_length;

    modport frontend (
        output match_enable,
        input  match_suc,
        output ready_to_xfer,
        output xfer_data_vld,
        output xfer_data,
        output end_of_packet,
        output new_dest_port,
        output new_prior,
        output new_length
    );

    modport arbiter (
        input  match_enable,
        output match_suc,
        input  ready_to_xfer,
        input  xfer_data_vld,
        input  xfer_data,
        input  end_of_packet,
        input  new_dest_port,
        input  new_prior,
        input  new_length
    );

endinterface

/* common/switch_pkg.sv */
package switch_pkg;

    // packet word and buffer geometry
    localparam int data_w       = 16;
    localparam int buf_depth    = 64;   // words per port buffer
    localparam int ptr_w        = 6;    // log2 of buf_depth
    localparam int len_w        = 9;
    localparam int dport_w      = 4;
    localparam int prio_w       = 3;
    localparam int num_in_ports = 2;

    // write side states of the frontend
    localparam logic [1:0] wr_idle = 2'd0;  // waiting for header word
    localparam logic [1:0] wr_head = 2'd1;  // header stored, first body word next
    localparam logic [1:0] wr_body = 2'd2;
    localparam logic [1:0] wr_tail = 2'd3;  // next word closes the packet

    // transfer side states of the frontend
    localparam logic [1:0] xs_idle  = 2'd0;
    localparam logic [1:0] xs_run   = 2'd1;  // one buffer read per cycle
    localparam logic [1:0] xs_stall = 2'd2;  // read side caught the write side

    // header word layout, msb first
    typedef struct packed {
        logic [len_w-1:0]   length;     // words incl. header
        logic [prio_w-1:0]  prior;
        logic [dport_w-1:0] dest_port;
    } pkt_hdr_t;

    // first word of a packet is read both ways
    typedef union packed {
        logic [data_w-1:0] raw;
        pkt_hdr_t          hdr;
    } pkt_word_t;

endpackage

/* port_wr_frontend/port_wr_frontend.sv */
module port_wr_frontend #(
    parameter int unsigned port_id = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_sop,   // with header word
    input  logic                  wr_eop,   // with last word
    input  logic                  wr_vld,
    input  switch_pkg::pkt_word_t wr_data,
    output logic                  pause,
    frontend_if.frontend          fe
);
    import switch_pkg::*;

    logic [1:0]         wr_st;
    logic [1:0]         xs;
    logic [data_w-1:0]  buf_mem [buf_depth];  // circular packet buffer
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [len_w-1:0]   wr_cnt;      // words of current packet written
    logic [len_w-1:0]   rd_cnt;      // words of current packet read
    logic [len_w-1:0]   xfer_len;    // length of packet in transfer
    logic [len_w-1:0]   pend_len;    // length captured with early grant
    logic               pend_grant;  // grant seen while still draining
    logic               hdr_wr;
    logic               rd_last;
    logic               near_full;
    logic               wait_grant;

    assign hdr_wr = (wr_st == wr_idle) && wr_vld && wr_sop;  // header word this cycle

    // write state machine, counts words against header length
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_st  <= wr_idle;
            wr_cnt <= '0;
        end else if (wr_vld) begin
            case (wr_st)
                wr_idle: if (wr_sop) begin
                    wr_cnt <= len_w'(1);
                    wr_st  <= (wr_data.hdr.length == len_w'(2)) ? wr_tail : wr_head;
                end
                wr_head, wr_body: begin
                    wr_cnt <= wr_cnt + len_w'(1);
                    // one word left after this one
                    wr_st  <= (wr_cnt + len_w'(2) == fe.new_length) ? wr_tail : wr_body;
                end
                default: wr_st <= wr_idle;  // tail word written
            endcase
        end
    end

    // buffer store and header decode
    always_ff @(posedge clk) begin
        if (wr_vld) begin
            buf_mem[wr_ptr] <= wr_data.raw;
        end
        if (hdr_wr) begin
            fe.new_dest_port <= wr_data.hdr.dest_port;
            fe.new_prior     <= wr_data.hdr.prior;
            fe.new_length    <= wr_data.hdr.length;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_vld) begin
            wr_ptr <= wr_ptr + ptr_w'(1);  // wraps at buf_depth
        end
    end

    // request held until the arbiter grants
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fe.match_enable <= 1'b0;
        end else if (hdr_wr) begin
            fe.match_enable <= 1'b1;
        end else if (fe.match_suc) begin
            fe.match_enable <= 1'b0;
        end
    end

    assign fe.ready_to_xfer = (xs == xs_idle) && (fe.match_suc || pend_grant);
    assign rd_last          = (rd_cnt == xfer_len - len_w'(1));

    // keeps a grant that lands before the previous packet drained
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_grant <= 1'b0;
        end else if (xs == xs_idle) begin
            pend_grant <= 1'b0;  // consumed by ready_to_xfer
        end else if (fe.match_suc) begin
            pend_grant <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fe.match_suc && xs != xs_idle) begin
            pend_len <= fe.new_length;  // header may be replaced before use
        end
    end

    // transfer state machine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xs       <= xs_idle;
            rd_ptr   <= '0;
            rd_cnt   <= '0;
            xfer_len <= '0;
        end else begin
            case (xs)
                xs_idle: if (fe.ready_to_xfer) begin
                    xs       <= xs_run;
                    rd_cnt   <= '0;
                    xfer_len <= pend_grant ? pend_len : fe.new_length;
                end
                xs_run: begin
                    rd_ptr <= rd_ptr + ptr_w'(1);
                    rd_cnt <= rd_cnt + len_w'(1);
                    if (rd_last) begin
                        xs <= xs_idle;
                    end else if (rd_ptr + ptr_w'(1) == wr_ptr) begin
                        xs <= xs_stall;  // nothing written ahead yet
                    end
                end
                default: if (rd_ptr != wr_ptr) begin
                    xs <= xs_run;
                end
            endcase
        end
    end

    // output stream, one cycle behind the read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fe.xfer_data_vld <= 1'b0;
            fe.end_of_packet <= 1'b0;
        end else begin
            fe.xfer_data_vld <= (xs == xs_run);
            fe.end_of_packet <= (xs == xs_run) && rd_last;
        end
    end

    always_ff @(posedge clk) begin
        if (xs == xs_run) begin
            fe.xfer_data.raw <= buf_mem[rd_ptr];
        end
    end

    // stop the sender when the buffer is nearly full
    // or a complete packet still waits for its grant
    assign near_full  = (wr_ptr + ptr_w'(1) == rd_ptr) || (wr_ptr + ptr_w'(2) == rd_ptr);
    assign wait_grant = fe.match_enable && !fe.match_suc &&
                        ((wr_st == wr_idle) || (wr_vld && wr_eop));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pause <= 1'b0;
        end else begin
            pause <= near_full || wait_grant;
        end
    end

endmodule

/* source/switch_ingress_top.sv */
module switch_ingress_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // port 0 write side
    input  logic                           wr_sop_0,
    input  logic                           wr_eop_0,
    input  logic                           wr_vld_0,
    input  logic [switch_pkg::data_w-1:0]  wr_data_0,
    output logic                           pause_0,
    // port 1 write side
    input  logic                           wr_sop_1,
    input  logic                           wr_eop_1,
    input  logic                           wr_vld_1,
    input  logic [switch_pkg::data_w-1:0]  wr_data_1,
    output logic                           pause_1,
    // shared stream to packet memory
    output logic                           out_vld,
    output logic [switch_pkg::data_w-1:0]  out_data,
    output logic                           out_sop,
    output logic                           out_eop,
    output logic                           out_src_port,
    output logic [switch_pkg::dport_w-1:0] out_dest_port,
    output logic [switch_pkg::prio_w-1:0]  out_prior,
    output logic [switch_pkg::len_w-1:0]   out_length
);

    frontend_if fe_0 ();  // port 0 to arbiter
    frontend_if fe_1 ();

    port_wr_frontend #(.port_id(0)) u_fe0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop_0),
        .wr_eop  (wr_eop_0),
        .wr_vld  (wr_vld_0),
        .wr_data (wr_data_0),
        .pause   (pause_0),
        .fe      (fe_0.frontend)
    );

    port_wr_frontend #(.port_id(1)) u_fe1 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_sop  (wr_sop_1),
        .wr_eop  (wr_eop_1),
        .wr_vld  (wr_vld_1),
        .wr_data (wr_data_1),
        .pause   (pause_1),
        .fe      (fe_1.frontend)
    );

    xfer_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .fe0           (fe_0.arbiter),
        .fe1           (fe_1.arbiter),
        .out_vld       (out_vld),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_data      (out_data),
        .out_src_port  (out_src_port),
        .out_dest_port (out_dest_port),
        .out_prior     (out_prior),
        .out_length    (out_length)
    );

endmodule

/* source/xfer_arbiter.sv */
module xfer_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    frontend_if.arbiter                    fe0,
    frontend_if.arbiter                    fe1,
    output logic                           out_vld,
    output logic                           out_sop,
    output logic                           out_eop,
    output switch_pkg::pkt_word_t          out_data,
    output logic                           out_src_port,
    output logic [switch_pkg::dport_w-1:0] out_dest_port,
    output logic [switch_pkg::prio_w-1:0]  out_prior,
    output logic [switch_pkg::len_w-1:0]   out_length
);
    import switch_pkg::*;

    logic [num_in_ports-1:0] req;
    logic                    rr_ptr;      // favored port
    logic                    busy;        // packet in flight
    logic                    sel;         // port owning the output
    logic                    sop_arm;     // next valid word is first
    logic                    grant_fire;
    logic                    grant_port;
    logic                    s_vld;
    logic                    s_eop;
    pkt_word_t               s_data;

    assign req        = {fe1.match_enable, fe0.match_enable};
    assign grant_fire = !busy && !out_vld && (req != '0);  // output fully idle
    assign grant_port = req[rr_ptr] ? rr_ptr : ~rr_ptr;

    assign fe0.match_suc = grant_fire && !grant_port;
    assign fe1.match_suc = grant_fire && grant_port;

    // selected stream
    assign s_vld  = sel ? fe1.xfer_data_vld : fe0.xfer_data_vld;
    assign s_eop  = sel ? fe1.end_of_packet : fe0.end_of_packet;
    assign s_data = sel ? fe1.xfer_data : fe0.xfer_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr  <= 1'b0;
            busy    <= 1'b0;
            sel     <= 1'b0;
            sop_arm <= 1'b0;
        end else begin
            if (grant_fire) begin
                busy   <= 1'b1;
                sel    <= grant_port;
                rr_ptr <= ~grant_port;  // other port favored next
            end else if (busy && s_vld && s_eop) begin
                busy <= 1'b0;
            end
            if (fe0.ready_to_xfer || fe1.ready_to_xfer) begin
                sop_arm <= 1'b1;
            end else if (busy && s_vld) begin
                sop_arm <= 1'b0;
            end
        end
    end

    // output register stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
            out_sop <= 1'b0;
            out_eop <= 1'b0;
        end else begin
            out_vld <= busy && s_vld;
            out_sop <= busy && s_vld && sop_arm;
            out_eop <= busy && s_vld && s_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && s_vld) begin
            out_data <= s_data;
        end
        if (grant_fire) begin  // header fields held for the whole packet
            out_src_port  <= grant_port;
            out_dest_port <= grant_port ? fe1.new_dest_port : fe0.new_dest_port;
            out_prior     <= grant_port ? fe1.new_prior : fe0.new_prior;
            out_length    <= grant_port ? fe1.new_length : fe0.new_length;
        end
    end

endmodule

/* tb/ingress_checker.sv */
module ingress_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wr_vld_0,      // sent words, port 0
    input  logic [15:0] wr_data_0,
    input  logic        wr_vld_1,
    input  logic [15:0] wr_data_1,
    input  logic        pause_0,
    input  logic        pause_1,
    input  logic        out_vld,       // shared output stream
    input  logic [15:0] out_data,
    input  logic        out_sop,
    input  logic        out_eop,
    input  logic        out_src_port,
    input  logic [3:0]  out_dest_port,
    input  logic [2:0]  out_prior,
    input  logic [8:0]  out_length,
    output int          errors,
    output int          q_words,       // words sent but not yet seen
    output logic        in_pkt,
    output int          pause_cycles
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] ref_q0 [$];    // port 0 words, oldest first
    logic [15:0] ref_q1 [$];
    logic [15:0] hdr = '0;      // header word of packet on output
    logic        cur_port = 1'b0;
    logic        busy = 1'b0;   // between out_sop and out_eop
    logic        rst_seen = 1'b0;  // reset applied at an earlier edge
    int          word_idx = 0;
    int          err_cnt = 0;
    int          pause_cnt = 0;
    int          q_cnt = 0;
    int          since_rst = 0;

    assign errors       = err_cnt;
    assign q_words      = q_cnt;
    assign in_pkt       = busy;
    assign pause_cycles = pause_cnt;

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_low(input string name, input logic val);
        if (val !== 1'b0) begin
            $display("ERROR %s: got 0x%h expected 0x0 around reset", name, val);
            err_cnt++;
        end
    endtask

    task automatic check_word();
        logic [15:0] exp_word;
        bit          found;
        found = 1'b0;
        exp_word = '0;
        if (out_sop) begin
            if (busy) begin
                $display("packet from port %0d started before the last one ended", out_src_port);
                err_cnt++;
            end
            busy     = 1'b1;
            cur_port = out_src_port;
            word_idx = 0;
            hdr      = '0;
            if (!cur_port && ref_q0.size() > 0) hdr = ref_q0[0];  // head of port queue
            if (cur_port && ref_q1.size() > 0) hdr = ref_q1[0];
        end else if (!busy) begin
            $display("output word seen outside any packet");
            err_cnt++;
            return;
        end
        compare("out_src_port", 16'(out_src_port), 16'(cur_port));  // no interleave
        compare("out_dest_port", 16'(out_dest_port), 16'(hdr[3:0]));
        compare("out_prior", 16'(out_prior), 16'(hdr[6:4]));
        compare("out_length", 16'(out_length), 16'(hdr[15:7]));
        if (!cur_port && ref_q0.size() > 0) begin
            exp_word = ref_q0.pop_front();
            found    = 1'b1;
        end else if (cur_port && ref_q1.size() > 0) begin
            exp_word = ref_q1.pop_front();
            found    = 1'b1;
        end
        if (found) begin
            compare("out_data", out_data, exp_word);
        end else begin
            $display("port %0d put out a word that was never sent", cur_port);
            err_cnt++;
        end
        word_idx++;
        compare("out_eop", 16'(out_eop), 16'(word_idx == int'(hdr[15:7])));
        if (out_eop) begin
            compare("out_length", 16'(out_length), 16'(word_idx));  // words sop to eop
            busy = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (rst_seen && since_rst < 2) begin  // reset values, held a bit after release
            check_low("out_vld", out_vld);
            check_low("out_sop", out_sop);
            check_low("out_eop", out_eop);
            check_low("pause_0", pause_0);
            check_low("pause_1", pause_1);
        end
        if (!rst_n) rst_seen = 1'b1;
        since_rst = rst_n ? since_rst + 1 : 0;
        if (pause_0 || pause_1) pause_cnt++;
        if (rst_n && wr_vld_0) ref_q0.push_back(wr_data_0);
        if (rst_n && wr_vld_1) ref_q1.push_back(wr_data_1);
        if (rst_n && out_vld) check_word();
        q_cnt = ref_q0.size() + ref_q1.size();
    end

endmodule

/* tb/tb_top.sv */
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pause_limit = 2000;  // cycles a sender may sit on pause
    localparam int drain_limit = 5000;  // cycles for the output to empty

    logic             clk = 1'b0;
    logic             rst_n;
    logic [1:0]       wr_sop;           // index is the port
    logic [1:0]       wr_eop;
    logic [1:0]       wr_vld;
    logic [1:0][15:0] wr_data;
    logic [1:0]       pause;
    logic             out_vld;
    logic [15:0]      out_data;
    logic             out_sop;
    logic             out_eop;
    logic             out_src_port;
    logic [3:0]       out_dest_port;
    logic [2:0]       out_prior;
    logic [8:0]       out_length;
    int               chk_errors;
    int               chk_q_words;
    logic             chk_in_pkt;
    int               chk_pause_cycles;
    int unsigned      lcg_state [2];    // one generator per sender
    bit               timed_out = 1'b0;
    int               pass_cnt = 0;
    int               fail_cnt = 0;

    always #10 clk = ~clk;  // 20 ns period

    switch_ingress_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_sop_0      (wr_sop[0]),
        .wr_eop_0      (wr_eop[0]),
        .wr_vld_0      (wr_vld[0]),
        .wr_data_0     (wr_data[0]),
        .pause_0       (pause[0]),
        .wr_sop_1      (wr_sop[1]),
        .wr_eop_1      (wr_eop[1]),
        .wr_vld_1      (wr_vld[1]),
        .wr_data_1     (wr_data[1]),
        .pause_1       (pause[1]),
        .out_vld       (out_vld),
        .out_data      (out_data),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_src_port  (out_src_port),
        .out_dest_port (out_dest_port),
        .out_prior     (out_prior),
        .out_length    (out_length)
    );

    ingress_checker u_chk (
        .clk (clk), .rst_n (rst_n),
        .wr_vld_0 (wr_vld[0]), .wr_data_0 (wr_data[0]),
        .wr_vld_1 (wr_vld[1]), .wr_data_1 (wr_data[1]),
        .pause_0 (pause[0]), .pause_1 (pause[1]),
        .out_vld (out_vld), .out_data (out_data),
        .out_sop (out_sop), .out_eop (out_eop),
        .out_src_port (out_src_port), .out_dest_port (out_dest_port),
        .out_prior (out_prior), .out_length (out_length),
        .errors (chk_errors), .q_words (chk_q_words),
        .in_pkt (chk_in_pkt), .pause_cycles (chk_pause_cycles)
    );

    function automatic int unsigned next_rand(input int port);
        lcg_state[port] = lcg_state[port] * 32'd1103515245 + 32'd12345;
        return lcg_state[port] >> 8;  // low bits cycle too fast
    endfunction

    function automatic int rand_range(input int port, input int lo, input int hi);
        return lo + int'(next_rand(port) % 32'(hi - lo + 1));
    endfunction

    task automatic drive_idle(input int port);
        wr_vld[port]  = 1'b0;
        wr_sop[port]  = 1'b0;
        wr_eop[port]  = 1'b0;
        wr_data[port] = '0;
    endtask

    task automatic wait_unpaused(input int port);
        int n;
        n = 0;
        while (pause[port] && n < pause_limit && !timed_out) begin
            @(negedge clk);
            n++;
        end
        if (pause[port] && !timed_out) begin
            $display("timeout: pause on port %0d stayed high for %0d cycles", port, pause_limit);
            timed_out = 1'b1;
        end
    endtask

    // header word is length, priority, destination from the top bit down
    task automatic send_packet(input int port, input int len, input int gap_max);
        logic [15:0] word;
        int          prior;
        int          dest;
        for (int i = 0; i < len && !timed_out; i++) begin
            wait_unpaused(port);  // called at a falling edge
            if (i == 0) begin
                prior = rand_range(port, 0, 7);
                dest  = rand_range(port, 0, 15);
                word  = {9'(len), 3'(prior), 4'(dest)};
            end else begin
                word = 16'(next_rand(port));
            end
            wr_vld[port]  = 1'b1;
            wr_sop[port]  = (i == 0);
            wr_eop[port]  = (i == len - 1);
            wr_data[port] = word;
            @(negedge clk);
            drive_idle(port);
            repeat (rand_range(port, 0, gap_max)) @(negedge clk);
        end
    endtask

    task automatic send_stream(input int port, input int count, input int len_lo,
                               input int len_hi, input int gap_max);
        for (int k = 0; k < count && !timed_out; k++) begin
            send_packet(port, rand_range(port, len_lo, len_hi), gap_max);
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((chk_q_words != 0 || chk_in_pkt) && n < drain_limit && !timed_out) begin
            @(negedge clk);
            n++;
        end
        if ((chk_q_words != 0 || chk_in_pkt) && !timed_out) begin
            $display("timeout: %0d sent words still missing at the output", chk_q_words);
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int err_base, input bit other_fail);
        int errs;
        errs = chk_errors - err_base;
        if (errs == 0 && !other_fail && !timed_out) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d mismatches", name, errs);
        end
    endtask

    initial begin
        int base;
        int pause_base;
        rst_n        = 1'b0;
        wr_vld       = '0;
        wr_sop       = '0;
        wr_eop       = '0;
        wr_data      = '0;
        lcg_state[0] = 32'd30899;
        lcg_state[1] = 32'd30899;
        void'(next_rand(1));  // port 1 one step ahead
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        finish_test("reset_state", 0, 1'b0);

        base = chk_errors;
        send_packet(0, rand_range(0, 2, 60), 0);
        wait_drained();
        finish_test("single_packet", base, 1'b0);

        base = chk_errors;
        send_packet(0, 2, 1);   // shortest legal packet
        send_packet(1, 60, 1);  // longest
        send_stream(0, 3, 2, 60, 2);
        send_stream(1, 3, 2, 60, 2);
        wait_drained();
        finish_test("header_decode", base, 1'b0);

        base = chk_errors;
        fork
            send_stream(0, 12, 2, 60, 3);
            send_stream(1, 12, 2, 60, 3);
        join
        wait_drained();
        finish_test("concurrent_ports", base, 1'b0);

        base       = chk_errors;
        pause_base = chk_pause_cycles;
        fork
            send_stream(0, 6, 40, 60, 0);
            send_stream(1, 6, 40, 60, 0);
        join
        wait_drained();
        if (chk_pause_cycles == pause_base) begin
            $display("pause never went high while long packets were sent back to back");
        end
        finish_test("back_pressure", base, chk_pause_cycles == pause_base);

        $display("summary: %0d tests passed, %0d tests failed, %0d mismatches",
                 pass_cnt, fail_cnt, chk_errors);
        if (fail_cnt == 0 && chk_errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
